// ==== cpuPkg.sv ====
package cpuPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths with a meaning
    //////////////////////////////////////////////////////////////////////

    // One data byte, registers and bus payload
    typedef logic [7:0] byteT;
    // ROM or data bus address
    typedef logic [7:0] addrT;
    // Arithmetic operation, high nibble of the instruction byte
    typedef logic [3:0] aluOpT;

    // Arithmetic operation codes
    localparam aluOpT aluAdd        = 4'h0;
    localparam aluOpT aluSub        = 4'h1;
    localparam aluOpT aluAnd        = 4'h2;
    localparam aluOpT aluOr         = 4'h3;
    localparam aluOpT aluXor        = 4'h4;
    localparam aluOpT aluShiftLeft  = 4'h5;
    localparam aluOpT aluShiftRight = 4'h6;
    localparam aluOpT aluIncrement  = 4'h7;
    // Compare codes, result is 0x01 or 0x00
    localparam aluOpT aluEqual      = 4'h8;
    localparam aluOpT aluGreater    = 4'h9;
    localparam aluOpT aluLess       = 4'hA;

    // Low nibble opcodes, 0x9 to 0xC and 0xF fall into idle
    typedef enum logic [3:0] {
        readA    = 4'h0,
        readB    = 4'h1,
        writeA   = 4'h2,
        writeB   = 4'h3,
        mathsA   = 4'h4,
        mathsB   = 4'h5,
        branch   = 4'h6,
        gotoAddr = 4'h7,
        gotoIdle = 4'h8,
        loadImmA = 4'hD,
        loadImmB = 4'hE
    } instrT;

    //////////////////////////////////////////////////////////////////////
    // Sequencer states
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        idle         = 5'h00,
        vector0      = 5'h01,
        vector1      = 5'h02,
        vector2      = 5'h03,
        decode       = 5'h04,
        readStart    = 5'h05,
        readAddr     = 5'h06,
        readWait     = 5'h07,
        readLoad     = 5'h08,
        writeStart   = 5'h09,
        writeIssue   = 5'h0A,
        mathsLoad    = 5'h0B,
        mathsWait    = 5'h0C,
        branchStart  = 5'h0D,
        branchCheck  = 5'h0E,
        branchWait   = 5'h0F,
        gotoStart    = 5'h10,
        gotoLoad     = 5'h11,
        gotoWait     = 5'h12,
        loadImmStart = 5'h13,
        loadImmLoad  = 5'h14,
        loadImmWait  = 5'h15
    } stateT;

    // Where a register load takes its byte from
    typedef enum logic [1:0] {
        fromBus = 2'd0,
        fromRom = 2'd1,
        fromAlu = 2'd2
    } regSourceT;

    // Fixed addresses
    localparam addrT resetPc     = 8'h00;
    localparam addrT irqAVector  = 8'hFF;
    localparam addrT irqBVector  = 8'hFE;
    localparam addrT idleBusAddr = 8'hFF;

    // Interrupt lines
    localparam int irqCount = 2;

endpackage

// ==== cpuAlu.sv ====
`timescale 1ns/1ps

module cpuAlu (
    input  cpuPkg::aluOpT aluOp,
    input  cpuPkg::byteT  regA,
    input  cpuPkg::byteT  regB,
    output cpuPkg::byteT  aluResult,
    output logic          branchTaken
);

    // Set for the three compare codes
    logic isCompare;

    always_comb begin
        case (aluOp)
            // Plain arithmetic, 8-bit wraparound
            cpuPkg::aluAdd:        aluResult = regA + regB;
            cpuPkg::aluSub:        aluResult = regA - regB;
            // Bitwise
            cpuPkg::aluAnd:        aluResult = regA & regB;
            cpuPkg::aluOr:         aluResult = regA | regB;
            cpuPkg::aluXor:        aluResult = regA ^ regB;
            // Single operand on A
            cpuPkg::aluShiftLeft:  aluResult = regA << 1;
            cpuPkg::aluShiftRight: aluResult = regA >> 1;
            cpuPkg::aluIncrement:  aluResult = regA + 8'd1;
            // Compares give 0x01 when they hold
            cpuPkg::aluEqual: begin
                aluResult = (regA == regB) ? 8'h01 : 8'h00;
            end
            cpuPkg::aluGreater: begin
                aluResult = (regA > regB) ? 8'h01 : 8'h00;
            end
            cpuPkg::aluLess: begin
                aluResult = (regA < regB) ? 8'h01 : 8'h00;
            end
            // Unused codes
            default:               aluResult = 8'h00;
        endcase
    end

    assign isCompare = (aluOp == cpuPkg::aluEqual) ||
                       (aluOp == cpuPkg::aluGreater) ||
                       (aluOp == cpuPkg::aluLess);

    // Sequencer samples this in its branch stage only
    assign branchTaken = isCompare && aluResult[0];

endmodule

// ==== cpuRegisterBus.sv ====
`timescale 1ns/1ps

module cpuRegisterBus (
    input  logic              CLK,
    input  logic              RESET,
    input  logic              loadRegA,
    input  logic              loadRegB,
    input  cpuPkg::regSourceT regSource,
    input  logic              busAddrLoad,
    input  logic              busWrite,
    input  logic              writeFromB,
    input  cpuPkg::byteT      romData,
    input  cpuPkg::byteT      busDataIn,
    input  cpuPkg::byteT      aluResult,
    output cpuPkg::byteT      regA,
    output cpuPkg::byteT      regB,
    output cpuPkg::addrT      busAddr,
    output cpuPkg::byteT      busDataOut,
    output logic              busWe
);

    // Byte that goes into the selected register
    cpuPkg::byteT regIn;

    //////////////////////////////////////////////////////////////////////
    // Working registers
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (regSource)
            cpuPkg::fromBus: regIn = busDataIn;
            cpuPkg::fromRom: regIn = romData;
            cpuPkg::fromAlu: regIn = aluResult;
            default:         regIn = busDataIn;
        endcase
    end

    // Payload, loaded on strobe only
    always_ff @(posedge CLK) begin
        if (loadRegA) begin
            regA <= regIn;
        end
        if (loadRegB) begin
            regB <= regIn;
        end
        // Write data captured with the strobe
        if (busWrite) begin
            busDataOut <= writeFromB ? regB : regA;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Bus address and write strobe
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busAddr <= cpuPkg::idleBusAddr;
            busWe   <= 1'b0;
        end else begin
            // Operand byte is the address, idle value between accesses
            if (busAddrLoad || busWrite) begin
                busAddr <= romData;
            end else begin
                busAddr <= cpuPkg::idleBusAddr;
            end
            busWe <= busWrite;
        end
    end

    // A read and a write never start in the same cycle
    accessExclusive: assert property (@(posedge CLK) disable iff (RESET)
        !(busAddrLoad && busWrite));

endmodule

// ==== cpuSequencer.sv ====
`timescale 1ns/1ps

module cpuSequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  cpuPkg::byteT                  romData,
    input  logic                          branchTaken,
    input  logic [cpuPkg::irqCount-1:0]   irqRaise,
    output cpuPkg::addrT                  romAddress,
    output logic [cpuPkg::irqCount-1:0]   irqAck,
    output cpuPkg::aluOpT                 aluOp,
    output logic                          loadRegA,
    output logic                          loadRegB,
    output cpuPkg::regSourceT             regSource,
    output logic                          busAddrLoad,
    output logic                          busWrite,
    output logic                          writeFromB
);

    // FSM and fetch state
    cpuPkg::stateT               state;
    cpuPkg::stateT               stateNext;
    cpuPkg::addrT                pc;
    cpuPkg::addrT                pcNext;
    logic [1:0]                  offset;
    logic [1:0]                  offsetNext;
    // Latched instruction fields
    cpuPkg::aluOpT               aluOpNext;
    logic                        regSelB;
    logic                        regSelBNext;
    logic [cpuPkg::irqCount-1:0] irqAckNext;
    // Register load request, split into A or B below
    logic                        regLoad;

    // ROM answers one cycle after the address, so fetch runs ahead
    assign romAddress = pc + cpuPkg::addrT'(offset);

    assign loadRegA   = regLoad && !regSelB;
    assign loadRegB   = regLoad && regSelB;
    assign writeFromB = regSelB;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state   <= cpuPkg::decode;
            pc      <= cpuPkg::resetPc;
            offset  <= 2'd0;
            aluOp   <= cpuPkg::aluAdd;
            regSelB <= 1'b0;
            irqAck  <= '0;
        end else begin
            state   <= stateNext;
            pc      <= pcNext;
            offset  <= offsetNext;
            aluOp   <= aluOpNext;
            regSelB <= regSelBNext;
            irqAck  <= irqAckNext;
        end
    end

    always_comb begin
        // Hold everything, strobes idle
        stateNext   = state;
        pcNext      = pc;
        offsetNext  = 2'd0;
        aluOpNext   = aluOp;
        regSelBNext = regSelB;
        irqAckNext  = '0;
        regLoad     = 1'b0;
        regSource   = cpuPkg::fromBus;
        busAddrLoad = 1'b0;
        busWrite    = 1'b0;

        case (state)
            //////////////////////////////////////////////////////////////////////
            // Idle and interrupt vector fetch
            //////////////////////////////////////////////////////////////////////
            // Line 0 has priority
            cpuPkg::idle: begin
                if (irqRaise[0]) begin
                    stateNext  = cpuPkg::vector0;
                    pcNext     = cpuPkg::irqAVector;
                    irqAckNext = 2'b01;
                end else if (irqRaise[1]) begin
                    stateNext  = cpuPkg::vector0;
                    pcNext     = cpuPkg::irqBVector;
                    irqAckNext = 2'b10;
                end
            end
            // Vector address on the ROM
            cpuPkg::vector0: stateNext = cpuPkg::vector1;
            // Handler start address arrives
            cpuPkg::vector1: begin
                pcNext    = romData;
                stateNext = cpuPkg::vector2;
            end
            // First handler byte in flight
            cpuPkg::vector2: stateNext = cpuPkg::decode;

            //////////////////////////////////////////////////////////////////////
            // Decode, romData holds the instruction at pc
            //////////////////////////////////////////////////////////////////////
            cpuPkg::decode: begin
                aluOpNext   = cpuPkg::aluOpT'(romData[7:4]);
                offsetNext  = 2'd1;
                regSelBNext = 1'b0;
                case (cpuPkg::instrT'(romData[3:0]))
                    cpuPkg::readA:    stateNext = cpuPkg::readStart;
                    cpuPkg::readB: begin
                        stateNext   = cpuPkg::readStart;
                        regSelBNext = 1'b1;
                    end
                    cpuPkg::writeA:   stateNext = cpuPkg::writeStart;
                    cpuPkg::writeB: begin
                        stateNext   = cpuPkg::writeStart;
                        regSelBNext = 1'b1;
                    end
                    cpuPkg::mathsA:   stateNext = cpuPkg::mathsLoad;
                    cpuPkg::mathsB: begin
                        stateNext   = cpuPkg::mathsLoad;
                        regSelBNext = 1'b1;
                    end
                    cpuPkg::branch:   stateNext = cpuPkg::branchStart;
                    cpuPkg::gotoAddr: stateNext = cpuPkg::gotoStart;
                    cpuPkg::loadImmA: stateNext = cpuPkg::loadImmStart;
                    cpuPkg::loadImmB: begin
                        stateNext   = cpuPkg::loadImmStart;
                        regSelBNext = 1'b1;
                    end
                    // Go to idle, also dropped and unused opcodes
                    cpuPkg::gotoIdle: stateNext = cpuPkg::idle;
                    default:          stateNext = cpuPkg::idle;
                endcase
            end

            // Read, operand is the bus address
            cpuPkg::readStart: stateNext = cpuPkg::readAddr;
            cpuPkg::readAddr: begin
                busAddrLoad = 1'b1;
                stateNext   = cpuPkg::readWait;
            end
            // Next fetch starts while RAM answers
            cpuPkg::readWait: begin
                pcNext    = pc + 8'd2;
                stateNext = cpuPkg::readLoad;
            end
            cpuPkg::readLoad: begin
                regLoad   = 1'b1;
                regSource = cpuPkg::fromBus;
                stateNext = cpuPkg::decode;
            end

            // Write, operand is the bus address
            cpuPkg::writeStart: begin
                pcNext    = pc + 8'd2;
                stateNext = cpuPkg::writeIssue;
            end
            cpuPkg::writeIssue: begin
                busWrite  = 1'b1;
                stateNext = cpuPkg::decode;
            end

            // Arithmetic, single byte
            cpuPkg::mathsLoad: begin
                regLoad   = 1'b1;
                regSource = cpuPkg::fromAlu;
                pcNext    = pc + 8'd1;
                stateNext = cpuPkg::mathsWait;
            end
            cpuPkg::mathsWait: stateNext = cpuPkg::decode;

            // Branch, prefetch pc+2 in case it is not taken
            cpuPkg::branchStart: begin
                offsetNext = 2'd2;
                stateNext  = cpuPkg::branchCheck;
            end
            cpuPkg::branchCheck: begin
                if (branchTaken) begin
                    pcNext    = romData;
                    stateNext = cpuPkg::branchWait;
                end else begin
                    pcNext    = pc + 8'd2;
                    stateNext = cpuPkg::decode;
                end
            end
            cpuPkg::branchWait: stateNext = cpuPkg::decode;

            // Goto
            cpuPkg::gotoStart: stateNext = cpuPkg::gotoLoad;
            cpuPkg::gotoLoad: begin
                pcNext    = romData;
                stateNext = cpuPkg::gotoWait;
            end
            cpuPkg::gotoWait: stateNext = cpuPkg::decode;

            // Load immediate
            cpuPkg::loadImmStart: stateNext = cpuPkg::loadImmLoad;
            cpuPkg::loadImmLoad: begin
                regLoad   = 1'b1;
                regSource = cpuPkg::fromRom;
                pcNext    = pc + 8'd2;
                stateNext = cpuPkg::loadImmWait;
            end
            cpuPkg::loadImmWait: stateNext = cpuPkg::decode;

            default: stateNext = cpuPkg::idle;
        endcase
    end

    // At most one register load or bus strobe per cycle
    loadExclusive: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0({loadRegA, loadRegB, busAddrLoad, busWrite}));

    // Ack is a single-cycle pulse on one line
    irqAckPulse: assert property (@(posedge CLK) disable iff (RESET)
        (irqAck != '0) |=> (irqAck == '0));
    irqAckOneHot: assert property (@(posedge CLK) disable iff (RESET)
        $onehot0(irqAck));

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
    input  logic                        CLK,
    input  logic                        RESET,
    output cpuPkg::addrT                romAddress,
    input  cpuPkg::byteT                romData,
    output cpuPkg::addrT                busAddr,
    output cpuPkg::byteT                busDataOut,
    output logic                        busWe,
    input  cpuPkg::byteT                busDataIn,
    input  logic [cpuPkg::irqCount-1:0] irqRaise,
    output logic [cpuPkg::irqCount-1:0] irqAck
);

    // Sequencer to register unit
    logic              loadRegA;
    logic              loadRegB;
    cpuPkg::regSourceT regSource;
    logic              busAddrLoad;
    logic              busWrite;
    logic              writeFromB;
    // Arithmetic paths
    cpuPkg::aluOpT     aluOp;
    cpuPkg::byteT      regA;
    cpuPkg::byteT      regB;
    cpuPkg::byteT      aluResult;
    logic              branchTaken;

    // FSM, program counter and interrupt handling
    cpuSequencer sequencer_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .romData     (romData),
        .branchTaken (branchTaken),
        .irqRaise    (irqRaise),
        .romAddress  (romAddress),
        .irqAck      (irqAck),
        .aluOp       (aluOp),
        .loadRegA    (loadRegA),
        .loadRegB    (loadRegB),
        .regSource   (regSource),
        .busAddrLoad (busAddrLoad),
        .busWrite    (busWrite),
        .writeFromB  (writeFromB)
    );

    // Combinational arithmetic on A and B
    cpuAlu alu_i (
        .aluOp       (aluOp),
        .regA        (regA),
        .regB        (regB),
        .aluResult   (aluResult),
        .branchTaken (branchTaken)
    );

    // Registers A and B, data bus outputs
    cpuRegisterBus registerBus_i (
        .CLK         (CLK),
        .RESET       (RESET),
        .loadRegA    (loadRegA),
        .loadRegB    (loadRegB),
        .regSource   (regSource),
        .busAddrLoad (busAddrLoad),
        .busWrite    (busWrite),
        .writeFromB  (writeFromB),
        .romData     (romData),
        .busDataIn   (busDataIn),
        .aluResult   (aluResult),
        .regA        (regA),
        .regB        (regB),
        .busAddr     (busAddr),
        .busDataOut  (busDataOut),
        .busWe       (busWe)
    );

endmodule

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

    // Memory size, clock and run length
    localparam int memDepth        = 256;
    localparam int clockPeriod     = 20;
    localparam int cyclesPerRecord = 64;
    // Quiet cycles watched after the last record
    localparam int tailCycles      = 16;

    logic                        CLK;
    logic                        RESET;
    cpuPkg::addrT                romAddress;
    cpuPkg::byteT                romData;
    cpuPkg::addrT                busAddr;
    cpuPkg::byteT                busDataOut;
    logic                        busWe;
    cpuPkg::byteT                busDataIn;
    logic [cpuPkg::irqCount-1:0] irqRaise;
    logic [cpuPkg::irqCount-1:0] irqAck;

    // Program image and data memory
    cpuPkg::byteT rom [memDepth];
    cpuPkg::byteT ram [memDepth];

    // Ordered W and I records, I keeps its line mask in recData
    string        recKind [$];
    string        recName [$];
    cpuPkg::addrT recAddr [$];
    cpuPkg::byteT recData [$];

    int recordCount;
    int nextRec;
    int errorCount;
    int checkCount;
    int cycles;

    cpuTop dut_i (
        .CLK        (CLK),
        .RESET      (RESET),
        .romAddress (romAddress),
        .romData    (romData),
        .busAddr    (busAddr),
        .busDataOut (busDataOut),
        .busWe      (busWe),
        .busDataIn  (busDataIn),
        .irqRaise   (irqRaise),
        .irqAck     (irqAck)
    );

    initial begin
        CLK = 1'b0;
        forever #(clockPeriod / 2) CLK = ~CLK;
    end

    //////////////////////////////////////////////////////////////////////
    // Memory models
    //////////////////////////////////////////////////////////////////////

    // Both answer one cycle after the address, RAM takes busWe writes
    always @(posedge CLK) begin
        romData   <= rom[romAddress];
        busDataIn <= ram[busAddr];
        if (busWe === 1'b1) begin
            ram[busAddr] <= busDataOut;
        end
    end

    task automatic fillMemories;
        int i;
        for (i = 0; i < memDepth; i++) begin
            // Background differs at every address
            rom[i] = cpuPkg::byteT'(i) ^ 8'h5A;
            ram[i] = ~cpuPkg::byteT'(i);
        end
    endtask

    task automatic readStimulus;
        int    fd;
        int    n;
        int    addr;
        int    v0;
        int    v1;
        string line;
        string kind;
        string name;
        fd = $fopen("cpuStimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file cpuStimulus.txt");
            errorCount++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s", kind);
            // Blank lines and comment lines
            if (n != 1 || kind[0] == "#") begin
                continue;
            end
            recordCount++;
            if (kind == "R") begin
                n = $sscanf(line, "%s %h %h %h", kind, addr, v0, v1);
                rom[addr % memDepth] = cpuPkg::byteT'(v0);
                // Operand byte of a two-byte instruction
                if (n == 4) begin
                    rom[(addr + 1) % memDepth] = cpuPkg::byteT'(v1);
                end
            end else if (kind == "M") begin
                n = $sscanf(line, "%s %h %h", kind, addr, v0);
                ram[addr % memDepth] = cpuPkg::byteT'(v0);
            end else if (kind == "I") begin
                n = $sscanf(line, "%s %h", kind, v0);
                recKind.push_back(kind);
                recName.push_back($sformatf("irqMask%0h", v0));
                recAddr.push_back(8'h00);
                recData.push_back(cpuPkg::byteT'(v0));
            end else if (kind == "W") begin
                n = $sscanf(line, "%s %s %h %h", kind, name, addr, v0);
                recKind.push_back(kind);
                recName.push_back(name);
                recAddr.push_back(cpuPkg::addrT'(addr));
                recData.push_back(cpuPkg::byteT'(v0));
            end else begin
                $display("unknown record kind %s in the stimulus file", kind);
                errorCount++;
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic compareField(input string testName, input string field,
                                input logic [7:0] expected, input logic [7:0] actual);
        checkCount++;
        if (actual !== expected) begin
            $display("error %s %s expected %h actual %h", testName, field, expected, actual);
            errorCount++;
        end
    endtask

    // Bus quiet and no acknowledge
    task automatic checkIdleOutputs(input string testName);
        compareField(testName, "busWe", 8'h00, {7'b0, busWe});
        compareField(testName, "irqAck", 8'h00, {6'b0, irqAck});
        compareField(testName, "busAddr", 8'hFF, busAddr);
    endtask

    // Line 0 wins over line 1
    function automatic logic [1:0] grantedLine(input logic [1:0] mask);
        if (mask[0]) begin
            return 2'b01;
        end else if (mask[1]) begin
            return 2'b10;
        end
        return 2'b00;
    endfunction

    task automatic applyReset;
        int i;
        for (i = 0; i < 4; i++) begin
            @(posedge CLK);
            // Outputs are defined from the first reset edge on
            if (i > 0) begin
                checkIdleOutputs("reset");
            end
        end
        RESET <= 1'b0;
        @(posedge CLK);
        checkIdleOutputs("afterReset");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Program run, one pass per rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic runProgram;
        int   limit;
        int   quiet;
        int   missing;
        int   i;
        logic irqPending;
        logic weLast;
        limit      = cyclesPerRecord * recordCount;
        quiet      = 0;
        irqPending = 1'b0;
        weLast     = 1'b0;
        while (quiet < tailCycles) begin
            @(posedge CLK);
            cycles++;
            // Each write against the next expected one
            if (busWe === 1'b1) begin
                if (weLast) begin
                    $display("busWe stayed high for more than one cycle at address %h", busAddr);
                    errorCount++;
                end else if (nextRec < recKind.size() && recKind[nextRec] == "W") begin
                    compareField(recName[nextRec], "address", recAddr[nextRec], busAddr);
                    compareField(recName[nextRec], "data", recData[nextRec], busDataOut);
                    nextRec++;
                end else begin
                    $display("unexpected write of %h to address %h", busDataOut, busAddr);
                    errorCount++;
                end
            end
            weLast = (busWe === 1'b1);
            // Acknowledge ends a request, a second cycle of it has none
            if (irqAck !== 2'b00) begin
                if (irqPending) begin
                    compareField(recName[nextRec], "irqAck",
                                 {6'b0, grantedLine(recData[nextRec][1:0])}, {6'b0, irqAck});
                    irqRaise   <= '0;
                    irqPending = 1'b0;
                    nextRec++;
                end else begin
                    $display("irqAck %b seen without a pending request", irqAck);
                    errorCount++;
                end
            end else if (!irqPending && nextRec < recKind.size() && recKind[nextRec] == "I") begin
                // Earlier writes all seen
                irqRaise   <= recData[nextRec][1:0];
                irqPending = 1'b1;
            end
            if (nextRec == recKind.size()) begin
                quiet++;
            end
            if (cycles >= limit) begin
                missing = 0;
                for (i = nextRec; i < recKind.size(); i++) begin
                    if (recKind[i] == "W") begin
                        missing++;
                    end
                end
                $display("timeout after %0d cycles with %0d expected writes still missing",
                         cycles, missing);
                errorCount++;
                return;
            end
        end
    endtask

    initial begin
        RESET       = 1'b1;
        romData     = '0;
        busDataIn   = '0;
        irqRaise    = '0;
        errorCount  = 0;
        checkCount  = 0;
        recordCount = 0;
        nextRec     = 0;
        cycles      = 0;
        fillMemories();
        readStimulus();
        if (errorCount == 0) begin
            applyReset();
            runProgram();
        end
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== cpuStimulus.txt ====
# R addr byte [byte] is a ROM instruction, M addr byte a RAM preset
# I mask raises interrupt lines, W name addr data is an expected bus write
# Load immediate and write
R 00 0D 5A  # A = 5A
R 02 0E C3  # B = C3
R 04 02 10  # write A
R 06 03 11  # write B
W loadWriteA 10 5A
W loadWriteB 11 C3
# Read A and B, then each arithmetic code with its result written
M 20 A6
M 21 5C
R 08 00 20  # read A
R 0A 01 21  # read B
R 0C 04     # add into A
R 0D 02 30
R 0F 14     # subtract
R 10 02 31
R 12 44     # xor
R 13 02 32
R 15 24     # and
R 16 02 33
R 18 34     # or
R 19 02 34
R 1B 54     # shift left
R 1C 02 35
R 1E 64     # shift right
R 1F 02 36
R 21 74     # increment
R 22 02 37
R 24 A5     # less into B
R 25 03 38
R 27 95     # greater into B
R 28 03 39
R 2A 84     # equal into A
R 2B 02 3A
W mathsAdd 30 02
W mathsSub 31 A6
W mathsXor 32 FA
W mathsAnd 33 58
W mathsOr 34 5C
W mathsShiftLeft 35 B8
W mathsShiftRight 36 5C
W mathsIncrement 37 5D
W mathsLess 38 00
W mathsGreater 39 01
W mathsEqual 3A 00
# Branch and goto with A = 00 and B = 01
R 2D A6 31  # less holds, skips the next write
R 2F 02 40
R 31 96 35  # greater fails, falls through
R 33 03 41
R 35 07 39  # goto over a write
R 37 02 42
R 39 02 43
R 3B 08     # go to idle
W branchNotTaken 41 01
W gotoTarget 43 00
# Interrupt handlers and their vectors
R 50 0D 77
R 52 02 50
R 54 08
R 60 0E 99
R 62 03 60
R 64 08
R FE 50
R FF 60
I 2
W irqLine1 50 77
I 3
W irqLine0 60 99

// ==== cpuTop.f ====
cpuPkg.sv
cpuAlu.sv
cpuRegisterBus.sv
cpuSequencer.sv
cpuTop.sv
cpuTb.sv
